// File: design/ahb_bank_decode.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

module ahb_bank_decode import ahb_sram_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,

	input  logic [`AHB_AW-1:0]  haddr,
	input  htrans_t             htrans,
	input  logic                hwrite,
	input  hsize_t              hsize,
	input  logic [`AHB_DW-1:0]  hwdata,
	input  logic                hready,
	output logic                hready_resp,
	output logic [`AHB_DW-1:0]  hrdata,

	ahb_bank_if.dec             bank0,
	ahb_bank_if.dec             bank1
);

	logic       aphase_valid;
	logic       bank_hit;   // High when the address falls in bank 1
	logic [1:0] aphase_sel; // One-hot bank request, bit n for bank n
	logic [1:0] dph_owner;  // Bank owning the current data phase, zero when idle

	// Only NONSEQ and SEQ carry a real transfer
	assign aphase_valid = (htrans == HT_NONSEQ) || (htrans == HT_SEQ);
	assign bank_hit     = haddr[`BANK_BIT];
	assign aphase_sel   = {aphase_valid && bank_hit, aphase_valid && !bank_hit};

	assign bank0.sel    = aphase_sel[0];
	assign bank0.haddr  = haddr;
	assign bank0.hwrite = hwrite;
	assign bank0.hsize  = hsize;
	assign bank0.hwdata = hwdata;
	assign bank0.hready = hready;

	assign bank1.sel    = aphase_sel[1];
	assign bank1.haddr  = haddr;
	assign bank1.hwrite = hwrite;
	assign bank1.hsize  = hsize;
	assign bank1.hwdata = hwdata;
	assign bank1.hready = hready;

	// Ownership moves only when an address phase is accepted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_owner <= 2'b00;
		end else if (hready) begin
			dph_owner <= aphase_sel;
		end
	end

	// Response return mux
	always_comb begin
		case (dph_owner)
			2'b01: begin
				hready_resp = bank0.hready_resp;
				hrdata      = bank0.hrdata;
			end
			2'b10: begin
				hready_resp = bank1.hready_resp;
				hrdata      = bank1.hrdata;
			end
			default: begin
				hready_resp = 1'b1; // Idle data phase completes at once
				hrdata      = '0;
			end
		endcase
	end

endmodule

// File: design/ahb_bank_if.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

// Slave-side AHB signals for one SRAM bank
interface ahb_bank_if import ahb_sram_pkg::*; ();

	logic                sel;     // Address phase targets this bank
	logic [`AHB_AW-1:0]  haddr;
	logic                hwrite;
	hsize_t              hsize;
	logic [`AHB_DW-1:0]  hwdata;
	logic                hready;  // Bus-wide ready, qualifies sel

	// Driven back by the bank controller
	logic                hready_resp;
	logic [`AHB_DW-1:0]  hrdata;

	modport dec (
		output sel,
		output haddr,
		output hwrite,
		output hsize,
		output hwdata,
		output hready,
		input  hready_resp,
		input  hrdata
	);

	modport ctrl (
		input  sel,
		input  haddr,
		input  hwrite,
		input  hsize,
		input  hwdata,
		input  hready,
		output hready_resp,
		output hrdata
	);

endinterface

// File: design/ahb_sram_dual_bank.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

// Two half-width SRAM banks behind one AHB-lite slave port
module ahb_sram_dual_bank import ahb_sram_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic [`AHB_AW-1:0]   haddr,
	input  htrans_t              htrans,
	input  logic                 hwrite,
	input  hsize_t               hsize,
	input  logic [`AHB_DW-1:0]   hwdata,
	input  logic                 hready,
	output logic                 hready_resp,
	output logic [`AHB_DW-1:0]   hrdata,

	// Bank 0 SRAM pins
	output logic [`SRAM_AW-1:0]  sram0_addr,
	output logic [`SRAM_DW-1:0]  sram0_dq_out,
	output logic                 sram0_dq_oe,
	output logic                 sram0_ce_n,
	output logic                 sram0_we_n,
	output logic                 sram0_oe_n,
	output logic [1:0]           sram0_byte_n,
	input  logic [`SRAM_DW-1:0]  sram0_dq_in,

	// Bank 1 SRAM pins
	output logic [`SRAM_AW-1:0]  sram1_addr,
	output logic [`SRAM_DW-1:0]  sram1_dq_out,
	output logic                 sram1_dq_oe,
	output logic                 sram1_ce_n,
	output logic                 sram1_we_n,
	output logic                 sram1_oe_n,
	output logic [1:0]           sram1_byte_n,
	input  logic [`SRAM_DW-1:0]  sram1_dq_in
);

	ahb_bank_if bank0_if ();
	ahb_bank_if bank1_if ();

	ahb_bank_decode ahb_bank_decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.haddr       (haddr),
		.htrans      (htrans),
		.hwrite      (hwrite),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hready      (hready),
		.hready_resp (hready_resp),
		.hrdata      (hrdata),
		.bank0       (bank0_if.dec),
		.bank1       (bank1_if.dec)
	);

	// Lower bank window, BANK_BIT clear
	ahb_sram_halfwidth bank0_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (bank0_if.ctrl),
		.sram_addr   (sram0_addr),
		.sram_dq_out (sram0_dq_out),
		.sram_dq_oe  (sram0_dq_oe),
		.sram_ce_n   (sram0_ce_n),
		.sram_we_n   (sram0_we_n),
		.sram_oe_n   (sram0_oe_n),
		.sram_byte_n (sram0_byte_n),
		.sram_dq_in  (sram0_dq_in)
	);

	// Upper bank window, BANK_BIT set
	ahb_sram_halfwidth bank1_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (bank1_if.ctrl),
		.sram_addr   (sram1_addr),
		.sram_dq_out (sram1_dq_out),
		.sram_dq_oe  (sram1_dq_oe),
		.sram_ce_n   (sram1_ce_n),
		.sram_we_n   (sram1_we_n),
		.sram_oe_n   (sram1_oe_n),
		.sram_byte_n (sram1_byte_n),
		.sram_dq_in  (sram1_dq_in)
	);

endmodule

// File: design/ahb_sram_halfwidth.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

// One AHB-lite bank on a half-width asynchronous SRAM.
// Byte and halfword accesses take a single data-phase cycle, a word
// access is split into a low halfword cycle and a high halfword cycle.
module ahb_sram_halfwidth import ahb_sram_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,

	ahb_bank_if.ctrl             bus,

	output logic [`SRAM_AW-1:0]  sram_addr,
	output logic [`SRAM_DW-1:0]  sram_dq_out,
	output logic                 sram_dq_oe,
	output logic                 sram_ce_n,
	output logic                 sram_we_n,
	output logic                 sram_oe_n,
	output logic [1:0]           sram_byte_n,
	input  logic [`SRAM_DW-1:0]  sram_dq_in
);

	sram_state_t          state;
	logic                 hready_r;
	logic                 read_dph;
	logic                 half_sel;  // Halfword moved in this cycle, also SRAM address bit 0
	logic [`SRAM_AW-2:0]  addr_hi;   // Word index within the bank
	logic [`SRAM_DW-1:0]  rdata_buf; // Low half of a word read
	logic [`SRAM_DW-1:0]  rd_half;
	logic [1:0]           lane_mask;
	logic                 accept;
	logic                 aphase_word;
	logic                 word_step;

	assign accept      = bus.sel && bus.hready;
	assign aphase_word = (bus.hsize == HS_WORD);

	// First word cycle stalls the bus and moves on by itself
	assign word_step = !bus.hready && (state == ST_WORD_LO);

	// Byte lanes within the addressed halfword
	always_comb begin
		case (bus.hsize)
			HS_BYTE: lane_mask = bus.haddr[0] ? 2'b10 : 2'b01;
			HS_HALF: lane_mask = 2'b11;
			HS_WORD: lane_mask = 2'b11; // Both halves use both lanes
			default: lane_mask = 2'b11;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			hready_r    <= 1'b1;
			read_dph    <= 1'b0;
			half_sel    <= 1'b0;
			sram_ce_n   <= 1'b1;
			sram_we_n   <= 1'b1;
			sram_oe_n   <= 1'b1;
			sram_byte_n <= 2'b11;
			sram_dq_oe  <= 1'b0;
		end else if (bus.hready) begin
			if (bus.sel) begin
				state       <= aphase_word ? ST_WORD_LO : ST_SHORT;
				hready_r    <= !aphase_word;
				read_dph    <= !bus.hwrite;
				half_sel    <= !aphase_word && bus.haddr[1]; // Word starts on the low half
				sram_ce_n   <= 1'b0;
				sram_we_n   <= !bus.hwrite;
				sram_oe_n   <= bus.hwrite;
				sram_byte_n <= ~lane_mask;
				sram_dq_oe  <= bus.hwrite;
			end else begin
				// Idle or the other bank, park the SRAM
				state       <= ST_IDLE;
				hready_r    <= 1'b1;
				read_dph    <= 1'b0;
				half_sel    <= 1'b0;
				sram_ce_n   <= 1'b1;
				sram_we_n   <= 1'b1;
				sram_oe_n   <= 1'b1;
				sram_byte_n <= 2'b11;
				sram_dq_oe  <= 1'b0;
			end
		end else if (word_step) begin
			state    <= ST_WORD_HI;
			hready_r <= 1'b1;
			half_sel <= 1'b1; // Strobes stay as they are for the high half
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_hi <= bus.haddr[`BANK_BIT-1:2];
		end
		if (word_step && read_dph) begin
			rdata_buf <= sram_dq_in;
		end
	end

	assign sram_addr = {addr_hi, half_sel};

	// Write data is taken from the hwdata lanes of the current halfword
	assign sram_dq_out = half_sel ? bus.hwdata[`AHB_DW-1:`SRAM_DW] : bus.hwdata[`SRAM_DW-1:0];

	// The pins carry our own write data during a write
	assign rd_half = read_dph ? sram_dq_in : '0;

	// Narrow reads repeat the halfword on both halves
	assign bus.hrdata      = {rd_half, (state == ST_WORD_HI) ? rdata_buf : rd_half};
	assign bus.hready_resp = hready_r;

endmodule

// File: design/ahb_sram_params.svh
`ifndef AHB_SRAM_PARAMS_SVH
`define AHB_SRAM_PARAMS_SVH

// AHB-lite bus widths
`define AHB_DW 32
`define AHB_AW 32

// Each SRAM carries one half of the bus
`define SRAM_DW (`AHB_DW / 2)

// Halfwords per bank
`define SRAM_DEPTH 2048
`define SRAM_AW $clog2(`SRAM_DEPTH)

// Address bit that picks the bank, also the byte size of one bank window
`define BANK_BIT 12

`endif

// File: design/ahb_sram_pkg.sv
package ahb_sram_pkg;

	// AHB transfer type as seen on htrans
	typedef enum logic [1:0] {
		HT_IDLE   = 2'b00,
		HT_BUSY   = 2'b01,
		HT_NONSEQ = 2'b10,
		HT_SEQ    = 2'b11
	} htrans_t;

	// Transfer sizes this slave supports
	typedef enum logic [2:0] {
		HS_BYTE = 3'b000,
		HS_HALF = 3'b001, // 16 bits, one SRAM cycle
		HS_WORD = 3'b010  // 32 bits, two SRAM cycles
	} hsize_t;

	// Data-phase state of one bank controller
	typedef enum logic [1:0] {
		ST_IDLE,    // No data phase owned
		ST_SHORT,   // Byte or halfword, single cycle
		ST_WORD_LO, // First word cycle, low halfword
		ST_WORD_HI  // Second word cycle, high halfword
	} sram_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f tb.f --top-module tb_ahb_sram -o tb_ahb_sram &&
./obj_dir/tb_ahb_sram > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

// File: tb.f
+incdir+design
design/ahb_sram_pkg.sv
design/ahb_bank_if.sv
design/ahb_bank_decode.sv
design/ahb_sram_halfwidth.sv
design/ahb_sram_dual_bank.sv
verif/sram_model.sv
verif/ahb_sram_checker.sv
verif/tb_ahb_sram.sv

// File: verif/ahb_sram_checker.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

// Follows every AHB transfer, mirrors writes into a byte shadow and compares reads
module ahb_sram_checker import ahb_sram_pkg::*; #(
	parameter logic [15:0] FILL0 = '0,
	parameter logic [15:0] FILL1 = '0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`AHB_AW-1:0]  haddr,
	input  htrans_t             htrans,
	input  logic                hwrite,
	input  hsize_t              hsize,
	input  logic [`AHB_DW-1:0]  hwdata,
	input  logic                hready_resp,
	input  logic [`AHB_DW-1:0]  hrdata,
	input  logic [1:0]          ce_n,      // Bit n for bank n
	input  logic [1:0]          we_n,
	input  logic [1:0]          oe_n,
	input  logic [3:0]          byte_n,    // Two bits per bank
	input  logic [1:0]          dq_oe,
	input  logic [2*`SRAM_AW-1:0] addr,    // Bank 1 above bank 0
	input  logic [31:0]         dq_out,
	input  logic [127:0]        tag_name,
	input  logic [31:0]         tag_exp,
	input  logic                tag_use_exp,
	output int                  n_tests,
	output int                  n_errors
);

	logic [7:0]          shadow [0:2**(`BANK_BIT+1)-1]; // Both bank windows, byte addressed
	logic                dph_valid = 1'b0;
	logic [`BANK_BIT:0]  dph_addr;
	logic                dph_write;
	hsize_t              dph_size;
	logic [127:0]        dph_name;
	logic [31:0]         dph_exp;
	logic                dph_use_exp;
	int                  stall_cycles;
	int                  errs_at_start;
	int                  tests = 0;
	int                  errs = 0;

	assign n_tests  = tests;
	assign n_errors = errs;

	task automatic check_val(input string sig, input logic [31:0] exp_val,
		input logic [31:0] got);
		if (exp_val !== got) begin
			$display("Fail %s exp %h got %h", sig, exp_val, got);
			errs++;
		end
	endtask

	// Same power-up contents as the two SRAM models
	initial begin
		logic [15:0] h;
		for (int x = 0; x < 2**(`BANK_BIT+1); x++) begin
			h = (x[`BANK_BIT] ? FILL1 : FILL0) ^ 16'(x[`BANK_BIT-1:1]);
			shadow[x] = x[0] ? h[15:8] : h[7:0];
		end
	end

	always @(posedge clk) begin
		logic [`BANK_BIT:0] b;
		logic [15:0]        h;
		logic [31:0]        exp_val;
		logic [31:0]        mask;
		logic               bank;
		logic               half;
		logic [`SRAM_AW-1:0] sram_a;
		if (!rst_n) begin
			dph_valid = 1'b0;
		end else begin
			if (!dph_valid) begin
				// Idle data phase, SRAMs parked
				check_val("hready_resp", 32'h1, 32'(hready_resp));
				check_val("hrdata", 32'h0, hrdata);
				check_val("ce_n", 32'h3, 32'(ce_n));
				check_val("we_n", 32'h3, 32'(we_n));
				check_val("oe_n", 32'h3, 32'(oe_n));
				check_val("byte_n", 32'hf, 32'(byte_n));
				check_val("dq_oe", 32'h0, 32'(dq_oe));
			end else begin
				b    = dph_addr;
				bank = b[`BANK_BIT];
				check_val("ce_n", bank ? 32'h1 : 32'h2, 32'(ce_n)); // Only the owner is enabled
				check_val("we_n", 32'(!dph_write), 32'(we_n[bank]));
				check_val("oe_n", 32'(dph_write), 32'(oe_n[bank]));
				check_val("dq_oe", 32'(dph_write), 32'(dq_oe[bank]));
				if (dph_size == HS_BYTE)
					check_val("byte_n", b[0] ? 32'h1 : 32'h2, 32'(byte_n[{bank, 1'b0} +: 2]));
				else
					check_val("byte_n", 32'h0, 32'(byte_n[{bank, 1'b0} +: 2]));
				half   = (dph_size == HS_WORD) ? hready_resp : b[1]; // Word moves low half first
				sram_a = bank ? addr[2*`SRAM_AW-1:`SRAM_AW] : addr[`SRAM_AW-1:0];
				check_val("sram_addr", 32'({b[`BANK_BIT-1:2], half}), 32'(sram_a));
				if (dph_write)
					check_val("sram_dq_out", 32'(half ? hwdata[31:16] : hwdata[15:0]),
						32'(bank ? dq_out[31:16] : dq_out[15:0]));
				if (!hready_resp) begin
					stall_cycles++;
				end else begin
					if (dph_size == HS_WORD) begin
						exp_val = {shadow[{b[`BANK_BIT:2], 2'd3}], shadow[{b[`BANK_BIT:2], 2'd2}],
							shadow[{b[`BANK_BIT:2], 2'd1}], shadow[{b[`BANK_BIT:2], 2'd0}]};
						mask = '1;
					end else begin
						h       = {shadow[{b[`BANK_BIT:1], 1'b1}], shadow[{b[`BANK_BIT:1], 1'b0}]};
						exp_val = {h, h}; // Narrow data shows on both halves
						mask    = (dph_size == HS_HALF) ? 32'hffff_ffff :
							(b[0] ? 32'hff00_ff00 : 32'h00ff_00ff);
					end
					if (dph_write) begin
						for (int k = 0; k < 4; k++) begin
							if (dph_size == HS_WORD || (dph_size == HS_HALF && k[1] == b[1]) ||
								2'(k) == b[1:0])
								shadow[{b[`BANK_BIT:2], 2'(k)}] = hwdata[8*k +: 8];
						end
					end else begin
						check_val("hrdata", exp_val & mask, hrdata & mask);
						if (dph_use_exp)
							check_val("hrdata", dph_exp & mask, hrdata & mask);
					end
					check_val("stall_cycles", (dph_size == HS_WORD) ? 32'h1 : 32'h0,
						32'(stall_cycles));
					tests++;
					$display("Test %0s %s addr %h size %0d %s", dph_name,
						dph_write ? "write" : "read", b, dph_size,
						(errs == errs_at_start) ? "ok" : "failed");
				end
			end
			// New address phase taken on this edge
			if (hready_resp) begin
				dph_valid     = (htrans == HT_NONSEQ) || (htrans == HT_SEQ);
				dph_addr      = haddr[`BANK_BIT:0];
				dph_write     = hwrite;
				dph_size      = hsize;
				dph_name      = tag_name;
				dph_exp       = tag_exp;
				dph_use_exp   = tag_use_exp;
				stall_cycles  = 0;
				errs_at_start = errs;
			end
		end
	end

endmodule

// File: verif/sram_model.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

// Asynchronous SRAM with byte enables.
// The split data pins are resolved here into one data bus.
module sram_model #(
	parameter logic [`SRAM_DW-1:0] FILL = '0
) (
	input  logic                 clk,
	input  logic [`SRAM_AW-1:0]  addr,
	input  logic [`SRAM_DW-1:0]  dq_out,
	input  logic                 dq_oe,
	input  logic                 ce_n,
	input  logic                 we_n,
	input  logic                 oe_n,
	input  logic [1:0]           byte_n,
	output logic [`SRAM_DW-1:0]  dq_in
);

	logic [`SRAM_DW-1:0] mem [0:`SRAM_DEPTH-1];
	logic [`SRAM_DW-1:0] rd_lanes;
	logic [`SRAM_DW-1:0] dq;  // Resolved data bus
	logic                sram_drive;

	// Power-up contents differ for every halfword
	initial begin
		for (int i = 0; i < `SRAM_DEPTH; i++) begin
			mem[i] = `SRAM_DW'(i) ^ FILL;
		end
	end

	assign sram_drive = !ce_n && !oe_n && we_n;
	assign rd_lanes   = {byte_n[1] ? 8'hff : mem[addr][15:8], byte_n[0] ? 8'hff : mem[addr][7:0]};

	// Pull-ups hold an undriven bus high
	assign dq    = dq_oe ? dq_out : (sram_drive ? rd_lanes : '1);
	assign dq_in = dq;

	always @(posedge clk) begin
		if (!ce_n && !we_n) begin
			if (!byte_n[0])
				mem[addr][7:0] <= dq[7:0];
			if (!byte_n[1])
				mem[addr][15:8] <= dq[15:8];
		end
	end

endmodule

// File: verif/tb_ahb_sram.sv
`timescale 1ns/1ps
`include "ahb_sram_params.svh"

module tb_ahb_sram import ahb_sram_pkg::*; ();

	localparam int          N_MAX      = 64;
	localparam int          N_RAND     = 24;
	localparam int          WAIT_LIMIT = 20; // Cycles allowed for one data phase
	localparam logic [15:0] FILL0      = 16'h3c5a;
	localparam logic [15:0] FILL1      = 16'hc3a5;

	logic                clk;
	logic                rst_n;
	logic [`AHB_AW-1:0]  haddr;
	htrans_t             htrans;
	logic                hwrite;
	hsize_t              hsize;
	logic [`AHB_DW-1:0]  hwdata;
	logic                hready;
	logic                hready_resp;
	logic [`AHB_DW-1:0]  hrdata;

	logic [`SRAM_AW-1:0] sram0_addr;
	logic [`SRAM_AW-1:0] sram1_addr;
	logic [`SRAM_DW-1:0] sram0_dq_out;
	logic [`SRAM_DW-1:0] sram1_dq_out;
	logic [`SRAM_DW-1:0] sram0_dq_in;
	logic [`SRAM_DW-1:0] sram1_dq_in;
	logic                sram0_dq_oe;
	logic                sram0_ce_n;
	logic                sram0_we_n;
	logic                sram0_oe_n;
	logic                sram1_dq_oe;
	logic                sram1_ce_n;
	logic                sram1_we_n;
	logic                sram1_oe_n;
	logic [1:0]          sram0_byte_n;
	logic [1:0]          sram1_byte_n;

	logic [127:0]        tag_name;  // Rides along with the address phase
	logic [31:0]         tag_exp;
	logic                tag_use_exp;
	int                  n_tests;
	int                  n_errors;

	// Stimulus table
	logic [127:0]        tbl_name [N_MAX];
	logic                tbl_write [N_MAX];
	hsize_t              tbl_size [N_MAX];
	logic [31:0]         tbl_addr [N_MAX];
	logic [31:0]         tbl_wdata [N_MAX];
	logic [31:0]         tbl_exp [N_MAX];
	logic                tbl_use_exp [N_MAX]; // Low leaves the check to the shadow memory
	int                  n_tbl;
	logic [31:0]         lfsr;
	logic                timed_out;

	always #10 clk = ~clk;

	assign hready = hready_resp; // Master returns ready straight to the slave

	ahb_sram_dual_bank ahb_sram_dual_bank_i (.*);

	sram_model #(.FILL(FILL0)) sram0_i (
		.clk    (clk),
		.addr   (sram0_addr),
		.dq_out (sram0_dq_out),
		.dq_oe  (sram0_dq_oe),
		.ce_n   (sram0_ce_n),
		.we_n   (sram0_we_n),
		.oe_n   (sram0_oe_n),
		.byte_n (sram0_byte_n),
		.dq_in  (sram0_dq_in)
	);

	sram_model #(.FILL(FILL1)) sram1_i (
		.clk    (clk),
		.addr   (sram1_addr),
		.dq_out (sram1_dq_out),
		.dq_oe  (sram1_dq_oe),
		.ce_n   (sram1_ce_n),
		.we_n   (sram1_we_n),
		.oe_n   (sram1_oe_n),
		.byte_n (sram1_byte_n),
		.dq_in  (sram1_dq_in)
	);

	ahb_sram_checker #(.FILL0(FILL0), .FILL1(FILL1)) checker_i (
		.clk, .rst_n, .haddr, .htrans, .hwrite, .hsize, .hwdata, .hready_resp, .hrdata,
		.ce_n   ({sram1_ce_n, sram0_ce_n}),
		.we_n   ({sram1_we_n, sram0_we_n}),
		.oe_n   ({sram1_oe_n, sram0_oe_n}),
		.byte_n ({sram1_byte_n, sram0_byte_n}),
		.dq_oe  ({sram1_dq_oe, sram0_dq_oe}),
		.addr   ({sram1_addr, sram0_addr}),
		.dq_out ({sram1_dq_out, sram0_dq_out}),
		.tag_name, .tag_exp, .tag_use_exp, .n_tests, .n_errors
	);

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic add_entry(input logic [127:0] name, input logic wr, input hsize_t sz,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [31:0] exp_val,
		input logic use_exp);
		tbl_name[n_tbl]    = name;
		tbl_write[n_tbl]   = wr;
		tbl_size[n_tbl]    = sz;
		tbl_addr[n_tbl]    = addr;
		tbl_wdata[n_tbl]   = wdata;
		tbl_exp[n_tbl]     = exp_val;
		tbl_use_exp[n_tbl] = use_exp;
		n_tbl++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic        wr;
		logic        bank_bit;
		hsize_t      sz;
		logic [3:0]  word_idx;
		logic [1:0]  low;
		add_entry("wr_word_b0", 1, HS_WORD, 32'h0000_0010, 32'h1122_3344, '0, 0);
		add_entry("rd_word_b0", 0, HS_WORD, 32'h0000_0010, '0, 32'h1122_3344, 1);
		add_entry("wr_word_b1", 1, HS_WORD, 32'h0000_1010, 32'hcafe_f00d, '0, 0);
		add_entry("rd_word_b1", 0, HS_WORD, 32'h0000_1010, '0, 32'hcafe_f00d, 1);
		add_entry("wr_byte_b0", 1, HS_BYTE, 32'h0000_0011, 32'h0000_aa00, '0, 0);
		add_entry("wr_half_b0", 1, HS_HALF, 32'h0000_0012, 32'hbeef_0000, '0, 0);
		add_entry("rd_merged", 0, HS_WORD, 32'h0000_0010, '0, 32'hbeef_aa44, 1);
		add_entry("rd_half_hi", 0, HS_HALF, 32'h0000_0012, '0, 32'hbeef_beef, 1);
		add_entry("rd_byte_1", 0, HS_BYTE, 32'h0000_0011, '0, 32'haa44_aa44, 1);
		// Upper address bits are ignored, bank 0 keeps its own data
		add_entry("rd_iso_b0", 0, HS_WORD, 32'h8000_0010, '0, 32'hbeef_aa44, 1);
		add_entry("rd_iso_b1", 0, HS_WORD, 32'h0000_1010, '0, 32'hcafe_f00d, 1);
		add_entry("pipe_wr", 1, HS_WORD, 32'h0000_0020, 32'h5a5a_a5a5, '0, 0);
		add_entry("pipe_rd", 0, HS_WORD, 32'h0000_0020, '0, 32'h5a5a_a5a5, 1);
		add_entry("alt_wr_b1", 1, HS_HALF, 32'h0000_1020, 32'h0000_1234, '0, 0);
		add_entry("alt_rd_b0", 0, HS_HALF, 32'h0000_0022, '0, 32'h5a5a_5a5a, 1);
		add_entry("alt_wr_b0", 1, HS_BYTE, 32'h0000_0023, 32'h7700_0000, '0, 0);
		add_entry("alt_rd_b1", 0, HS_WORD, 32'h0000_1020, '0, '0, 0);
		add_entry("alt_rd_b0w", 0, HS_WORD, 32'h0000_0020, '0, 32'h775a_a5a5, 1);
		for (int k = 0; k < N_RAND; k++) begin
			take_bits(1, r);
			wr = r[0];
			take_bits(2, r);
			sz = (r[1:0] == 2'd3) ? HS_WORD : hsize_t'({1'b0, r[1:0]});
			take_bits(1, r);
			bank_bit = r[0];
			take_bits(4, r);
			word_idx = r[3:0]; // Small window so transfers hit each other
			take_bits(2, r);
			low = (sz == HS_WORD) ? 2'b00 : ((sz == HS_HALF) ? {r[1], 1'b0} : r[1:0]);
			take_bits(32, r);
			add_entry("random", wr, sz, {19'd0, bank_bit, 6'd1, word_idx, low}, r, '0, 0);
		end
	endtask

	// Counted wait for the end of the current data phase, sampled mid-cycle
	task automatic wait_ready(output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < WAIT_LIMIT) begin
			@(negedge clk);
			ok = hready_resp;
			n++;
		end
	endtask

	initial begin
		logic ok;
		clk         = 1'b0;
		rst_n       = 1'b0;
		haddr       = '0;
		htrans      = HT_IDLE;
		hwrite      = 1'b0;
		hsize       = HS_BYTE;
		hwdata      = '0;
		tag_name    = '0;
		tag_exp     = '0;
		tag_use_exp = 1'b0;
		lfsr        = 32'h8e9c_dbd3;
		timed_out   = 1'b0;
		n_tbl       = 0;
		build_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk); // Idle bus after reset
		for (int i = 0; i < n_tbl && !timed_out; i++) begin
			haddr       <= tbl_addr[i];
			htrans      <= HT_NONSEQ;
			hwrite      <= tbl_write[i];
			hsize       <= tbl_size[i];
			tag_name    <= tbl_name[i];
			tag_exp     <= tbl_exp[i];
			tag_use_exp <= tbl_use_exp[i];
			wait_ready(ok);
			if (!ok) begin
				$display("Timeout: hready_resp stayed low before test %0d was accepted", i);
				timed_out = 1'b1;
			end else begin
				@(posedge clk);
				hwdata <= tbl_wdata[i]; // Data phase of the transfer just accepted
			end
		end
		htrans <= HT_IDLE;
		if (!timed_out) begin
			wait_ready(ok);
			if (!ok) begin
				$display("Timeout: the last data phase never completed");
				timed_out = 1'b1;
			end else begin
				repeat (4) @(posedge clk);
			end
		end
		$display("Tests %0d, errors %0d", n_tests, n_errors);
		if (timed_out || n_errors != 0)
			$display("ERRORS FOUND");
		else
			$display("NO ERRORS");
		$finish;
	end

endmodule
